//--- files.f
jtcore_pkg.sv
sdram_req_if.sv
jtcore_dwnld.sv
jtcore_cfg.sv
jtcore_rom_slot.sv
jtcore_sdram_arb.sv
jtcore_game.sv
tb_clk.sv
tb_sdram_model.sv
tb_jtcore_game.sv

//--- tb_jtcore_game.sv
/*
  Testbench for the ROM side of the game core. Loads a short ROM image,
  then reads both slots at random addresses against the model pattern.
  Main reads stay below byte 0x20000, so main and graphics fetches can
  be told apart by SDRAM address. The first failed check ends the run.
*/
`timescale 1ns/1ps

module tb_jtcore_game;

    localparam logic [31:0] SEED        = 32'h8dad_b87e;
    localparam int          N_LOAD      = 16;    // SDRAM bytes
    localparam int          N_PROM      = 8;
    localparam int          N_GFX       = 30;
    localparam int          N_MAIN      = 15;    // Pairs of reads
    localparam int          N_BLOCKED   = 8;     // Reads per pause or mask phase
    localparam int          OP_CYCLES   = 100;   // Worst case per operation
    localparam int          N_OPS       = N_LOAD + N_PROM + N_GFX + 2 * N_MAIN + 2 * N_BLOCKED;
    localparam real         WATCHDOG_NS = N_OPS * OP_CYCLES * 20.0;

    logic                               clk;
    logic                               reset;
    logic                               downloading;
    logic [jtcore_pkg::IOCTL_AW-1:0]    ioctl_addr;
    logic [7:0]                         ioctl_data;
    logic                               ioctl_wr;
    logic [jtcore_pkg::SDRAM_AW-1:0]    prog_addr;
    logic [7:0]                         prog_data;
    logic [1:0]                         prog_mask;
    logic                               prog_we;
    logic                               prom_we;
    logic                               sdram_req;
    logic [jtcore_pkg::SDRAM_AW-1:0]    sdram_addr;
    logic [31:0]                        data_read;
    logic                               data_rdy;
    logic                               sdram_ack;
    logic                               refresh_en;
    logic [31:0]                        dipsw;
    logic                               dip_pause;
    logic [3:0]                         gfx_en;
    logic [7:0]                         dipsw_a;
    logic [7:0]                         dipsw_b;
    logic [3:0]                         dipsw_c;
    logic                               gfx_cs;
    logic [jtcore_pkg::GFX_AW-1:0]      gfx_addr;
    logic [15:0]                        gfx_data;
    logic                               gfx_ok;
    logic                               main_cs;
    logic [jtcore_pkg::MAIN_AW-1:0]     main_addr;
    logic [7:0]                         main_data;
    logic                               main_ok;

    logic                               no_main_req;    // Main slot blocked
    logic                               no_gfx_req;     // Graphics slot blocked
    logic                               hit_only;       // Cache hit expected with no fetch
    logic [19:0]                        dip_fields;
    logic [19:0]                        dip_fields_q;
    logic [31:0]                        dipsw_q;
    int                                 errors = 0;

    tb_clk u_clk (.*);
    tb_sdram_model u_sdram (.*);
    jtcore_game jtcore_game_inst (.*);

    assign dip_fields = {dipsw_c, dipsw_b, dipsw_a};

    always @(posedge clk) begin
        dip_fields_q <= dip_fields;
        dipsw_q      <= dipsw;
    end

    task automatic end_with_failure(input string why);
        errors++;
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        end_with_failure($sformatf("Fail at %0t: %s = 0x%0h, expected 0x%0h",
                                   $time, name, got, exp));
    endtask

    // Read pattern of one SDRAM word
    function automatic logic [15:0] rom_word(input logic [jtcore_pkg::SDRAM_AW-1:0] word_addr);
        return word_addr[15:0] ^ 16'h5A5A;
    endfunction

    after_reset: assert property (@(posedge clk)
        reset |=> !sdram_req && !prog_we && !prom_we && !gfx_ok && !main_ok)
        else report_mismatch("reset outputs",
                             {$sampled(sdram_req), $sampled(prog_we), $sampled(prom_we),
                              $sampled(gfx_ok), $sampled(main_ok)}, 0);

    no_read_in_load: assert property (@(posedge clk) disable iff (reset)
        downloading |-> !sdram_req)
        else report_mismatch("sdram_req", $sampled(sdram_req), 0);

    prom_single: assert property (@(posedge clk) disable iff (reset) prom_we |=> !prom_we)
        else report_mismatch("prom_we", $sampled(prom_we), 0);

    prom_not_sdram: assert property (@(posedge clk) disable iff (reset) prom_we |-> !prog_we)
        else report_mismatch("prog_we", $sampled(prog_we), 0);

    refresh_idle: assert property (@(posedge clk) disable iff (reset) refresh_en |-> !sdram_req)
        else report_mismatch("sdram_req", $sampled(sdram_req), 0);

    dip_frozen: assert property (@(posedge clk) disable iff (reset)
        downloading |=> dip_fields == dip_fields_q)
        else report_mismatch("dipsw_c/b/a", $sampled(dip_fields), $sampled(dip_fields_q));

    dip_follow: assert property (@(posedge clk) disable iff (reset)
        !downloading |=> dip_fields == dipsw_q[19:0])
        else report_mismatch("dipsw_c/b/a", $sampled(dip_fields), $sampled(dipsw_q[19:0]));

    main_paused: assert property (@(posedge clk) disable iff (reset)
        no_main_req && sdram_req |-> sdram_addr >= jtcore_pkg::GFX_OFFSET)
        else end_with_failure($sformatf("Main slot fetched word 0x%0h while paused",
                                        $sampled(sdram_addr)));

    gfx_masked: assert property (@(posedge clk) disable iff (reset)
        no_gfx_req && sdram_req |-> sdram_addr < jtcore_pkg::GFX_OFFSET)
        else end_with_failure($sformatf("Graphics slot fetched word 0x%0h while masked",
                                        $sampled(sdram_addr)));

    hit_no_fetch: assert property (@(posedge clk) disable iff (reset) hit_only |-> !sdram_req)
        else report_mismatch("sdram_req", $sampled(sdram_req), 0);

    task automatic load_byte(input logic [jtcore_pkg::IOCTL_AW-1:0] a, input logic [7:0] d);
        logic                               prom;
        logic [jtcore_pkg::SDRAM_AW-1:0]    exp_addr;
        prom     = a >= jtcore_pkg::PROM_START;
        exp_addr = prom ? 22'(a - jtcore_pkg::PROM_START) : 22'(a >> 1);
        @(posedge clk);
        ioctl_addr <= a;
        ioctl_data <= d;
        ioctl_wr   <= 1'b1;
        dipsw      <= $urandom;        // Must not reach the DIP outputs
        @(posedge clk);
        ioctl_wr <= 1'b0;
        @(posedge clk);
        assert (prog_addr == exp_addr) else report_mismatch("prog_addr", prog_addr, exp_addr);
        if (prom) begin
            assert (prom_we) else report_mismatch("prom_we", prom_we, 1);
        end else begin
            assert (prog_we) else report_mismatch("prog_we", prog_we, 1);
            assert (prog_data == d) else report_mismatch("prog_data", prog_data, d);
            assert (prog_mask == (a[0] ? 2'b01 : 2'b10))
                else report_mismatch("prog_mask", prog_mask, a[0] ? 2'b01 : 2'b10);
            while (prog_we) @(posedge clk);     // Held until the SDRAM ack
        end
    endtask

    task automatic gfx_read(input logic [jtcore_pkg::GFX_AW-1:0] a);
        logic [15:0] exp;
        exp = rom_word(jtcore_pkg::GFX_OFFSET + 22'(a));
        @(posedge clk);
        gfx_cs   <= 1'b1;
        gfx_addr <= a;
        @(posedge clk);                 // ok still belongs to the old address
        do @(posedge clk); while (!gfx_ok);
        assert (gfx_data == exp) else report_mismatch("gfx_data", gfx_data, exp);
        gfx_cs <= 1'b0;
    endtask

    task automatic main_read(input logic [jtcore_pkg::MAIN_AW-1:0] a, input logic hit);
        logic [15:0] word;
        logic [7:0]  exp;
        word = rom_word(22'(a >> 1));
        exp  = a[0] ? word[15:8] : word[7:0];
        @(posedge clk);
        main_cs  <= 1'b1;
        main_addr <= a;
        hit_only <= hit;
        dipsw    <= $urandom;
        @(posedge clk);
        @(posedge clk);
        if (hit) begin
            assert (main_ok) else report_mismatch("main_ok", main_ok, 1);
            repeat (3) @(posedge clk);  // A wrong fetch reaches sdram_req by now
        end
        while (!main_ok) @(posedge clk);
        assert (main_data == exp) else report_mismatch("main_data", main_data, exp);
        main_cs  <= 1'b0;
        hit_only <= 1'b0;
    endtask

    initial begin
        #(WATCHDOG_NS);
        end_with_failure("Watchdog expired before the tests finished");
    end

    initial begin
        int                             i;
        logic [jtcore_pkg::GFX_AW-1:0]  last_gfx;
        logic [jtcore_pkg::MAIN_AW-1:0] last_main;
        void'($urandom(SEED));
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        dipsw       = $urandom;
        dip_pause   = 1'b0;
        gfx_en      = 4'hF;
        gfx_cs      = 1'b0;
        gfx_addr    = '0;
        main_cs     = 1'b0;
        main_addr   = '0;
        no_main_req = 1'b0;
        no_gfx_req  = 1'b0;
        hit_only    = 1'b0;
        @(posedge clk);
        while (reset) @(posedge clk);
        repeat (2) @(posedge clk);
        assert (refresh_en) else report_mismatch("refresh_en", refresh_en, 1);

        // Load with a graphics fetch parked behind it
        last_gfx = 18'($urandom);
        downloading <= 1'b1;
        gfx_cs      <= 1'b1;
        gfx_addr    <= last_gfx;
        for (i = 0; i < N_LOAD; i++) begin
            load_byte(25'($urandom_range(0, 32'(jtcore_pkg::PROM_START) - 1)), 8'($urandom));
        end
        for (i = 0; i < N_PROM; i++) begin
            load_byte(jtcore_pkg::PROM_START + 25'($urandom_range(0, 32'h1FFF)),
                      8'($urandom));
        end
        @(posedge clk);
        downloading <= 1'b0;
        gfx_read(last_gfx);

        for (i = 0; i < N_GFX; i++) begin
            last_gfx = 18'($urandom);
            gfx_read(last_gfx);
        end
        for (i = 0; i < N_MAIN; i++) begin
            last_main = 18'($urandom_range(0, 32'h1_FFFF));
            main_read(last_main, 1'b0);
            main_read({last_main[17:2], 2'($urandom)}, 1'b1);   // Same pair
        end

        // Paused CPU while graphics keeps going
        @(posedge clk);
        dip_pause <= 1'b1;
        repeat (3) @(posedge clk);
        no_main_req <= 1'b1;
        main_cs     <= 1'b1;
        main_addr   <= last_main ^ 18'h4;
        for (i = 0; i < N_BLOCKED; i++) begin
            last_gfx = 18'($urandom);
            gfx_read(last_gfx);
        end
        main_cs <= 1'b0;
        repeat (2) @(posedge clk);
        no_main_req <= 1'b0;
        dip_pause   <= 1'b0;

        // Graphics layer masked
        gfx_en <= 4'hE;
        repeat (3) @(posedge clk);
        no_gfx_req <= 1'b1;
        gfx_cs     <= 1'b1;
        gfx_addr   <= last_gfx ^ 18'h2;
        for (i = 0; i < N_BLOCKED; i++) begin
            main_read(18'($urandom_range(0, 32'h1_FFFF)), 1'b0);
        end
        gfx_cs <= 1'b0;
        repeat (2) @(posedge clk);
        no_gfx_req <= 1'b0;
        gfx_en     <= 4'hF;

        repeat (4) @(posedge clk);
        if (errors == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            end_with_failure("Checks failed during the run");
        end
    end

endmodule

//--- tb_sdram_model.sv
/*
  Behavioural SDRAM. Reads return a pattern computed from the word
  address, writes are logged but not stored.
  Serves one request at a time; ack and data_rdy each come 1 to 4
  cycles late.
*/
`timescale 1ns/1ps

module tb_sdram_model (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                sdram_req,
    input  logic [jtcore_pkg::SDRAM_AW-1:0]     sdram_addr,
    input  logic                                prog_we,
    input  logic [jtcore_pkg::SDRAM_AW-1:0]     prog_addr,
    input  logic [7:0]                          prog_data,
    input  logic [1:0]                          prog_mask,
    output logic                                sdram_ack,
    output logic                                data_rdy,
    output logic [31:0]                         data_read
);

    // Even word in the low half, the next word in the high half
    function automatic logic [31:0] read_pair(input logic [jtcore_pkg::SDRAM_AW-1:0] a);
        logic [15:0] lo;
        lo = a[15:0];
        return {(lo + 16'd1) ^ 16'h5A5A, lo ^ 16'h5A5A};
    endfunction

    task automatic wait_random();
        int n;
        n = $urandom_range(0, 3);
        repeat (n) @(posedge clk);
    endtask

    initial begin
        logic                               is_read;
        logic [jtcore_pkg::SDRAM_AW-1:0]    addr;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge clk);
            if (!reset && (sdram_req || prog_we)) begin
                wait_random();
                is_read = sdram_req;
                addr    = sdram_addr;        // Held by the arbiter until ack
                if (!is_read) begin
                    $display("sdram write: word 0x%06h mask %b data 0x%02h",
                             prog_addr, prog_mask, prog_data);
                end
                sdram_ack <= 1'b1;
                @(posedge clk);
                sdram_ack <= 1'b0;
                if (is_read) begin
                    wait_random();
                    data_read <= read_pair(addr);
                    data_rdy  <= 1'b1;
                    @(posedge clk);
                    data_rdy  <= 1'b0;
                end
            end
        end
    end

endmodule

//--- tb_clk.sv
/*
  Testbench clock and synchronous reset, 20 ns period.
  Reset is released on a rising edge after eight cycles.
*/
`timescale 1ns/1ps

module tb_clk (
    output logic clk,
    output logic reset
);

    localparam real PERIOD_NS    = 20.0;
    localparam int  RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- jtcore_game.sv
/*
  ROM side of the game core: loader, DIP latch, two cached ROM
  slots and the SDRAM read arbiter.
  sdram_addr carries prog_addr while downloading, reads otherwise.
  main_data is the low byte of a zero-extended slot output.
*/
`timescale 1ns/1ps

module jtcore_game (
    input  logic                                clk,
    input  logic                                reset,
    // ROM load
    input  logic                                downloading,
    input  logic [jtcore_pkg::IOCTL_AW-1:0]     ioctl_addr,
    input  logic [7:0]                          ioctl_data,
    input  logic                                ioctl_wr,
    output logic [jtcore_pkg::SDRAM_AW-1:0]     prog_addr,
    output logic [7:0]                          prog_data,
    output logic [1:0]                          prog_mask,   // Active low
    output logic                                prog_we,
    output logic                                prom_we,
    // SDRAM
    output logic                                sdram_req,
    output logic [jtcore_pkg::SDRAM_AW-1:0]     sdram_addr,
    input  logic [jtcore_pkg::SDRAM_DW-1:0]     data_read,
    input  logic                                data_rdy,
    input  logic                                sdram_ack,
    output logic                                refresh_en,
    // DIP switches and debug
    input  logic [31:0]                         dipsw,
    input  logic                                dip_pause,
    input  logic [3:0]                          gfx_en,
    output logic [7:0]                          dipsw_a,
    output logic [7:0]                          dipsw_b,
    output logic [3:0]                          dipsw_c,
    // ROM clients
    input  logic                                gfx_cs,
    input  logic [jtcore_pkg::GFX_AW-1:0]       gfx_addr,
    output logic [15:0]                         gfx_data,
    output logic                                gfx_ok,
    input  logic                                main_cs,
    input  logic [jtcore_pkg::MAIN_AW-1:0]      main_addr,
    output logic [7:0]                          main_data,
    output logic                                main_ok
);

    logic                               gfx_slot_en;
    logic                               main_slot_en;
    logic [15:0]                        main_dout;
    logic [jtcore_pkg::SDRAM_AW-1:0]    rd_addr;

    sdram_req_if gfx_bus();
    sdram_req_if main_bus();

    jtcore_dwnld u_dwnld (
        .clk         ( clk          ),
        .reset       ( reset        ),
        .downloading ( downloading  ),
        .ioctl_addr  ( ioctl_addr   ),
        .ioctl_data  ( ioctl_data   ),
        .ioctl_wr    ( ioctl_wr     ),
        .sdram_ack   ( sdram_ack    ),
        .prog_addr   ( prog_addr    ),
        .prog_data   ( prog_data    ),
        .prog_mask   ( prog_mask    ),
        .prog_we     ( prog_we      ),
        .prom_we     ( prom_we      )
    );

    jtcore_cfg u_cfg (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .downloading  ( downloading  ),
        .dip_pause    ( dip_pause    ),
        .gfx_en       ( gfx_en       ),
        .dipsw        ( dipsw        ),
        .dipsw_a      ( dipsw_a      ),
        .dipsw_b      ( dipsw_b      ),
        .dipsw_c      ( dipsw_c      ),
        .gfx_slot_en  ( gfx_slot_en  ),
        .main_slot_en ( main_slot_en )
    );

    jtcore_rom_slot u_gfx_slot (
        .clk   ( clk                  ),
        .reset ( reset                ),
        .en    ( gfx_slot_en          ),
        .cs    ( gfx_cs               ),
        .addr  ( gfx_addr             ),
        .kind  ( jtcore_pkg::SLOT_GFX ),
        .dout  ( gfx_data             ),
        .ok    ( gfx_ok               ),
        .bus   ( gfx_bus.slot         )
    );

    jtcore_rom_slot u_main_slot (
        .clk   ( clk                   ),
        .reset ( reset                 ),
        .en    ( main_slot_en          ),
        .cs    ( main_cs               ),
        .addr  ( main_addr             ),
        .kind  ( jtcore_pkg::SLOT_MAIN ),
        .dout  ( main_dout             ),
        .ok    ( main_ok               ),
        .bus   ( main_bus.slot         )
    );

    assign main_data = main_dout[7:0];

    jtcore_sdram_arb u_arb (
        .clk         ( clk          ),
        .reset       ( reset        ),
        .data_rdy    ( data_rdy     ),
        .sdram_ack   ( sdram_ack    ),
        .downloading ( downloading  ),
        .data_read   ( data_read    ),
        .sdram_req   ( sdram_req    ),
        .sdram_addr  ( rd_addr      ),
        .refresh_en  ( refresh_en   ),
        .gfx         ( gfx_bus.arb  ),
        .main        ( main_bus.arb )
    );

    assign sdram_addr = downloading ? prog_addr : rd_addr;

endmodule

//--- jtcore_sdram_arb.sv
/*
  Round-robin SDRAM read arbiter for the graphics and main slots.
  One read in flight; no new read starts while downloading, so any
  sdram_ack in that time belongs to the programming write.
  sdram_addr is only the read address; the top muxes in prog_addr.
*/
`timescale 1ns/1ps

module jtcore_sdram_arb (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                data_rdy,
    input  logic                                sdram_ack,
    input  logic                                downloading,
    input  logic [jtcore_pkg::SDRAM_DW-1:0]     data_read,
    output logic                                sdram_req,
    output logic [jtcore_pkg::SDRAM_AW-1:0]     sdram_addr,
    output logic                                refresh_en,
    sdram_req_if.arb                            gfx,
    sdram_req_if.arb                            main
);

    jtcore_pkg::arb_state_t     state;
    jtcore_pkg::slot_id_t       owner;     // Last granted slot
    jtcore_pkg::slot_id_t       pick;
    logic                       any_req;

    assign any_req = gfx.req || main.req;

    // Alternate when both ask, owner resets to main so gfx goes first
    always_comb begin
        if (gfx.req && main.req) begin
            pick = owner == jtcore_pkg::SLOT_GFX ? jtcore_pkg::SLOT_MAIN
                                                 : jtcore_pkg::SLOT_GFX;
        end else if (gfx.req) begin
            pick = jtcore_pkg::SLOT_GFX;
        end else begin
            pick = jtcore_pkg::SLOT_MAIN;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= jtcore_pkg::ARB_IDLE;
            owner      <= jtcore_pkg::SLOT_MAIN;
            gfx.grant  <= 1'b0;
            main.grant <= 1'b0;
        end else begin
            gfx.grant  <= 1'b0;
            main.grant <= 1'b0;
            case (state)
                jtcore_pkg::ARB_IDLE: begin
                    if (any_req && !downloading) begin
                        owner      <= pick;
                        state      <= jtcore_pkg::ARB_REQ;
                        gfx.grant  <= pick == jtcore_pkg::SLOT_GFX;
                        main.grant <= pick == jtcore_pkg::SLOT_MAIN;
                    end
                end
                jtcore_pkg::ARB_REQ: begin
                    if (sdram_ack) state <= jtcore_pkg::ARB_WAIT;
                end
                jtcore_pkg::ARB_WAIT: begin
                    if (data_rdy) state <= jtcore_pkg::ARB_IDLE;
                end
                default: state <= jtcore_pkg::ARB_IDLE;
            endcase
        end
    end

    // Read address follows the winner while idle
    always_ff @(posedge clk) begin
        if (state == jtcore_pkg::ARB_IDLE) begin
            sdram_addr <= pick == jtcore_pkg::SLOT_GFX ? gfx.addr : main.addr;
        end
    end

    assign sdram_req  = state == jtcore_pkg::ARB_REQ;
    assign refresh_en = state == jtcore_pkg::ARB_IDLE && !any_req;

    // Both slots see the bus, only the owner gets rdy
    assign gfx.data  = data_read;
    assign main.data = data_read;
    assign gfx.rdy   = state == jtcore_pkg::ARB_WAIT && data_rdy
                       && owner == jtcore_pkg::SLOT_GFX;
    assign main.rdy  = state == jtcore_pkg::ARB_WAIT && data_rdy
                       && owner == jtcore_pkg::SLOT_MAIN;

endmodule

//--- jtcore_rom_slot.sv
/*
  Cached ROM slot holding the last 32-bit pair read from SDRAM.
  kind picks the address rule: SLOT_GFX reads 16-bit words above
  GFX_OFFSET, SLOT_MAIN reads bytes from address 0.
  dout and ok refer to the address of the previous cycle, so a client
  holds addr until ok. The cache is only cleared by reset.
*/
`timescale 1ns/1ps

module jtcore_rom_slot (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                en,
    input  logic                                cs,
    input  logic [jtcore_pkg::MAIN_AW-1:0]      addr,
    input  jtcore_pkg::slot_id_t                kind,
    output logic [15:0]                         dout,
    output logic                                ok,
    sdram_req_if.slot                           bus
);

    logic                               wide16;
    logic [jtcore_pkg::SDRAM_AW-1:0]    fetch_addr;
    logic [jtcore_pkg::SDRAM_AW-1:0]    cache_addr;
    logic [31:0]                        cache_data;
    logic                               cache_valid;
    logic                               hit;
    logic                               busy;      // Fetch in flight
    logic                               start;
    logic [15:0]                        sel_data;

    assign wide16 = kind == jtcore_pkg::SLOT_GFX;

    // Even word address of the pair holding addr
    always_comb begin
        if (wide16) begin
            fetch_addr = jtcore_pkg::GFX_OFFSET + {4'd0, addr[17:1], 1'b0};
        end else begin
            fetch_addr = {5'd0, addr[17:2], 1'b0};   // Byte address halved
        end
    end

    always_comb begin
        if (wide16) begin
            sel_data = addr[0] ? cache_data[31:16] : cache_data[15:0];
        end else begin
            sel_data = {8'd0, cache_data[8*addr[1:0] +: 8]};
        end
    end

    assign hit   = cache_valid && cache_addr == fetch_addr;
    assign start = en && cs && !hit && !busy && !bus.rdy;

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.req     <= 1'b0;
            busy        <= 1'b0;
            cache_valid <= 1'b0;
            ok          <= 1'b0;
        end else begin
            ok <= cs && hit;
            if (bus.grant) begin
                bus.req <= 1'b0;
            end
            if (bus.rdy) begin
                busy        <= 1'b0;
                cache_valid <= 1'b1;
            end else if (start) begin
                bus.req <= 1'b1;
                busy    <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            bus.addr <= fetch_addr;      // Stable until the pair returns
        end
        if (bus.rdy) begin
            cache_data <= bus.data;
            cache_addr <= bus.addr;
        end
        if (cs && hit) begin
            dout <= sel_data;
        end
    end

endmodule

//--- jtcore_cfg.sv
/*
  DIP switch latch and slot fetch enables.
  Only dipsw[19:0] and gfx_en[0] are used by this core; the other
  bits belong to layers outside it. All outputs lag inputs by a cycle.
*/
`timescale 1ns/1ps

module jtcore_cfg (
    input  logic        clk,
    input  logic        reset,
    input  logic        downloading,
    input  logic        dip_pause,
    input  logic [3:0]  gfx_en,
    input  logic [31:0] dipsw,
    output logic [7:0]  dipsw_a,
    output logic [7:0]  dipsw_b,
    output logic [3:0]  dipsw_c,
    output logic        gfx_slot_en,
    output logic        main_slot_en
);

    // Settings frozen during a load so the game sees a stable value
    always_ff @(posedge clk) begin
        if (!downloading) begin
            {dipsw_c, dipsw_b, dipsw_a} <= dipsw[19:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            gfx_slot_en  <= 1'b0;
            main_slot_en <= 1'b0;
        end else begin
            gfx_slot_en  <= !downloading && gfx_en[0];   // Debug layer mask
            // Paused CPU fetches nothing
            main_slot_en <= !downloading && !dip_pause;
        end
    end

endmodule

//--- jtcore_dwnld.sv
/*
  Splits host loader bytes between SDRAM programming and the PROMs.
  Loader writes are only honoured while downloading is high.
  The host must not write again until prog_we has been acknowledged.
  prog_mask is active low, one byte lane per write.
*/
`timescale 1ns/1ps

module jtcore_dwnld (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                downloading,
    input  logic [jtcore_pkg::IOCTL_AW-1:0]     ioctl_addr,
    input  logic [7:0]                          ioctl_data,
    input  logic                                ioctl_wr,
    input  logic                                sdram_ack,
    output logic [jtcore_pkg::SDRAM_AW-1:0]     prog_addr,
    output logic [7:0]                          prog_data,
    output logic [1:0]                          prog_mask,
    output logic                                prog_we,
    output logic                                prom_we
);

    logic                               load_wr;
    logic                               is_prom;
    logic [jtcore_pkg::IOCTL_AW-1:0]    prom_offset;

    assign load_wr     = ioctl_wr && downloading;
    assign is_prom     = ioctl_addr >= jtcore_pkg::PROM_START;
    assign prom_offset = ioctl_addr - jtcore_pkg::PROM_START;

    // Write strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= load_wr && is_prom;    // Single cycle
            if (load_wr && !is_prom) begin
                prog_we <= 1'b1;
            end else if (sdram_ack) begin
                prog_we <= 1'b0;              // SDRAM took the byte
            end
        end
    end

    // Address, data and lane select
    always_ff @(posedge clk) begin
        if (load_wr) begin
            prog_data <= ioctl_data;
            if (is_prom) begin
                prog_addr <= prom_offset[jtcore_pkg::SDRAM_AW-1:0];
            end else begin
                prog_addr <= ioctl_addr[jtcore_pkg::SDRAM_AW:1];
                // Even byte goes to the low lane
                prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
            end
        end
    end

endmodule

//--- sdram_req_if.sv
/*
  Read request channel between one ROM slot and the SDRAM arbiter.
  addr is always an even word address; data returns two words.
  grant and rdy are single-cycle pulses. One read in flight per slot.
*/
`timescale 1ns/1ps

interface sdram_req_if;

    logic                               req;
    logic [jtcore_pkg::SDRAM_AW-1:0]    addr;
    logic                               grant;   // Request taken
    logic                               rdy;     // data valid this cycle
    logic [jtcore_pkg::SDRAM_DW-1:0]    data;

    // req/addr held until grant, req dropped the cycle after it
    modport slot (
        output req,
        output addr,
        input  grant,
        input  rdy,
        input  data
    );

    modport arb (
        input  req,
        input  addr,
        output grant,
        output rdy,
        output data
    );

endinterface

//--- jtcore_pkg.sv
/*
  Memory map and shared types of the ROM side of the game core.
  SDRAM addresses count 16-bit words and loader addresses count bytes.
  Offsets are fixed by the board layout and are not meant to be tuned.
*/
package jtcore_pkg;

    // SDRAM geometry
    localparam int SDRAM_AW = 22;          // Word address
    localparam int SDRAM_DW = 32;          // Two words per read burst

    // Host loader
    localparam int IOCTL_AW = 25;          // Byte address

    // Where the graphics ROM sits in SDRAM, in words
    localparam logic [SDRAM_AW-1:0] GFX_OFFSET = 22'h1_0000;

    // Loader bytes from here on go to the PROMs
    localparam logic [IOCTL_AW-1:0] PROM_START = 25'h6_0000;

    // Client address widths
    localparam int GFX_AW  = 18;           // 16-bit words
    localparam int MAIN_AW = 18;           // Bytes

    // SDRAM read arbiter
    typedef enum logic [1:0] {
        ARB_IDLE,   // Waiting for a slot request
        ARB_REQ,    // sdram_req high until ack
        ARB_WAIT    // Waiting for data_rdy
    } arb_state_t;

    // Slot identity, also used to pick the address rule of a slot
    typedef enum logic {
        SLOT_GFX,
        SLOT_MAIN
    } slot_id_t;

endpackage
